// ==== verilog/m1_defines.svh ====
`ifndef M1_DEFINES_SVH
`define M1_DEFINES_SVH

// exception entry point, bootstrap vectors (BEV=1)
`define EXC_VECTOR      32'hbfc0_0380

// status bit positions
`define STATUS_IE       0
`define STATUS_EXL      1
`define STATUS_BEV      22

// boot state: only BEV set
`define STATUS_RESET    (32'h1 << `STATUS_BEV)

// software writable status bits, IM[7:0] + EXL + IE
`define STATUS_WMASK    32'h0000_ff03

// cause bit positions
`define CAUSE_BD        31

// only the two software interrupt bits take mtc0 data
`define CAUSE_WMASK     32'h0000_0300

`endif

// ==== verilog/m1_pkg.sv ====
`default_nettype none

package m1_pkg;

    // memory operation decoded in execute
    typedef enum logic [2:0] {
        MEM_NONE = 3'd0,
        MEM_LW   = 3'd1,
        MEM_LB   = 3'd2,
        MEM_LBU  = 3'd3,
        MEM_SW   = 3'd4,
        MEM_SB   = 3'd5
    } mem_op_t;

    // values as written to Cause.ExcCode
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,  // load or fetch address error
        EXC_ADES = 5'd5,  // store address error
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10
    } exc_code_t;

    // cp0 register numbers, select 0 only
    typedef enum logic [4:0] {
        BADVADDR = 5'd8,
        STATUS   = 5'd12,
        CAUSE    = 5'd13,
        EPC      = 5'd14
    } cp0_addr_t;

    // data cache request sequencer
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_ASKING,   // req high, waiting for addr_ok
        DC_WAITING,  // accepted, waiting for data_ok
        DC_DONE      // data captured until commit
    } dc_state_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;  // memory address for loads and stores
        logic [31:0] rt_value;    // store data, mtc0 data
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_t     mem_op;
        logic        is_mfc0;
        logic        is_mtc0;
        logic        is_eret;
        cp0_addr_t   cp0_addr;
        logic        bd;          // item sits in a delay slot
        logic        ex;          // raised by an earlier stage
        exc_code_t   ex_code;
    } es_to_m1_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        gr_we;
        logic        ex;
    } m1_to_ms_t;

    // bypass info for decode, dest 0 = nothing to forward
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] result;
        logic        load_pending;
    } m1_fwd_t;

    // current item as seen by the cache unit and cp0
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] wdata;
        mem_op_t     mem_op;
        logic        is_mfc0;
        logic        is_mtc0;
        logic        is_eret;
        cp0_addr_t   cp0_addr;
        logic        bd;
        logic        ex;
        exc_code_t   ex_code;
    } m1_cmd_t;

    typedef struct packed {
        logic        op;     // 1 = write
        logic [31:0] addr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } dcache_req_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_req.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_req import m1_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire m1_cmd_t     cmd,
    input  wire              int_pending,
    input  wire              commit,
    output logic             req,
    output dcache_req_t      req_bus,
    input  wire              addr_ok,
    input  wire              data_ok,
    input  wire [31:0]       rdata,
    output logic             mem_done,
    output logic [31:0]      mem_rdata,
    output logic             addr_err,
    output logic [31:0]      bad_addr
);

    dc_state_t   state;
    logic        is_load;
    logic        is_store;
    logic        is_word;
    logic        go;        // item may go to the cache
    logic [1:0]  ofs;       // byte lane
    logic [31:0] rdata_q;
    logic [7:0]  byte_sel;

    assign ofs      = cmd.addr[1:0];
    assign is_load  = (cmd.mem_op == MEM_LW) || (cmd.mem_op == MEM_LB) || (cmd.mem_op == MEM_LBU);
    assign is_store = (cmd.mem_op == MEM_SW) || (cmd.mem_op == MEM_SB);
    assign is_word  = (cmd.mem_op == MEM_LW) || (cmd.mem_op == MEM_SW);

    // byte ops are always aligned
    assign addr_err = cmd.valid && is_word && (ofs != 2'b00);
    assign bad_addr = cmd.addr;

    assign go = cmd.valid && (is_load || is_store) && !addr_err && !cmd.ex && !int_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= DC_IDLE;
        end else begin
            case (state)
                DC_IDLE:    if (go) state <= addr_ok ? DC_WAITING : DC_ASKING;
                DC_ASKING:  if (addr_ok) state <= DC_WAITING;
                DC_WAITING: if (data_ok) state <= DC_DONE;
                DC_DONE:    if (commit) state <= DC_IDLE;  // held through back-pressure
                default:    state <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DC_WAITING && data_ok) begin
            rdata_q <= rdata;  // response buffer
        end
    end

    // request goes out in the first cycle already
    assign req = (state == DC_IDLE && go) || (state == DC_ASKING);

    always_comb begin
        req_bus.op   = is_store;
        req_bus.addr = cmd.addr;
        case (cmd.mem_op)
            MEM_SW:  req_bus.wstrb = 4'b1111;
            MEM_SB:  req_bus.wstrb = 4'b0001 << ofs;
            default: req_bus.wstrb = 4'b0000;
        endcase
        // byte store replicated on all lanes, strobe picks one
        req_bus.wdata = (cmd.mem_op == MEM_SB) ? {4{cmd.wdata[7:0]}} : cmd.wdata;
    end

    assign mem_done = (state == DC_DONE);
    assign byte_sel = rdata_q[{ofs, 3'b000} +: 8];

    always_comb begin
        case (cmd.mem_op)
            MEM_LB:  mem_rdata = {{24{byte_sel[7]}}, byte_sel};
            MEM_LBU: mem_rdata = {24'd0, byte_sel};
            default: mem_rdata = rdata_q;  // lw
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cp0_regs.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "m1_defines.svh"

module cp0_regs import m1_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire [5:0]        ext_int,
    input  wire m1_cmd_t     cmd,
    input  wire              commit,
    input  wire              addr_err,
    input  wire [31:0]       bad_addr,
    output logic [31:0]      cp0_rdata,
    output logic             int_pending,
    output logic             exc_taken,
    output logic             flush,
    output logic [31:0]      flush_target
);

    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] badvaddr;
    logic        int_raw;
    logic        int_seen;   // interrupt decision already made for this item
    logic        int_keep;
    logic        is_store;
    exc_code_t   exc_code;

    // enabled and unmasked request, not already in a handler
    assign int_raw = status[`STATUS_IE] && !status[`STATUS_EXL]
                     && (|(cause[15:8] & status[15:8]));

    // freeze the decision on the first cycle of an item
    // so a started cache access or a stalled result is never overtaken
    always_ff @(posedge clk) begin
        if (reset) begin
            int_seen <= 1'b0;
            int_keep <= 1'b0;
        end else if (commit) begin
            int_seen <= 1'b0;  // next item decides afresh
            int_keep <= 1'b0;
        end else if (cmd.valid && !int_seen) begin
            int_seen <= 1'b1;
            int_keep <= int_raw;
        end
    end

    assign int_pending = cmd.valid && (int_seen ? int_keep : int_raw);

    assign is_store  = (cmd.mem_op == MEM_SW) || (cmd.mem_op == MEM_SB);
    assign exc_taken = cmd.valid && (int_pending || cmd.ex || addr_err);

    // priority: interrupt, earlier stage, then address error
    always_comb begin
        if (int_pending) begin
            exc_code = EXC_INT;
        end else if (cmd.ex) begin
            exc_code = cmd.ex_code;
        end else if (is_store) begin
            exc_code = EXC_ADES;
        end else begin
            exc_code = EXC_ADEL;
        end
    end

    assign flush        = commit && (exc_taken || cmd.is_eret);
    assign flush_target = exc_taken ? `EXC_VECTOR : epc;  // eret returns to epc

    always_ff @(posedge clk) begin
        if (reset) begin
            status   <= `STATUS_RESET;
            cause    <= '0;
            epc      <= '0;
            badvaddr <= '0;
        end else begin
            if (commit && exc_taken) begin
                status[`STATUS_EXL] <= 1'b1;
                cause[`CAUSE_BD]    <= cmd.bd;
                cause[6:2]          <= exc_code;
                epc                 <= cmd.bd ? cmd.pc - 32'd4 : cmd.pc;  // back to the branch
                if (!int_pending && !cmd.ex) begin
                    badvaddr <= bad_addr;  // only the data side reports an address
                end
            end else if (commit && cmd.is_eret) begin
                status[`STATUS_EXL] <= 1'b0;
            end else if (commit && cmd.is_mtc0) begin
                case (cmd.cp0_addr)
                    STATUS:  status <= (status & ~`STATUS_WMASK) | (cmd.wdata & `STATUS_WMASK);
                    CAUSE:   cause  <= (cause & ~`CAUSE_WMASK) | (cmd.wdata & `CAUSE_WMASK);
                    EPC:     epc    <= cmd.wdata;
                    default: ;  // badvaddr is read only
                endcase
            end
            // hardware lines land in IP[7:2] every cycle, after any mtc0 above
            cause[15:10] <= ext_int;
        end
    end

    // mfc0 read port, unknown numbers give zero
    always_comb begin
        case (cmd.cp0_addr)
            BADVADDR: cp0_rdata = badvaddr;
            STATUS:   cp0_rdata = status;
            CAUSE:    cp0_rdata = cause;
            EPC:      cp0_rdata = epc;
            default:  cp0_rdata = '0;
        endcase
        if (!cmd.is_mfc0) begin
            cp0_rdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/m1_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module m1_stage import m1_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire              in_valid,
    input  wire es_to_m1_t   in_bus,
    output logic             allowin,
    output logic             out_valid,
    output m1_to_ms_t        out_bus,
    input  wire              ms_allowin,
    output m1_fwd_t          fwd,
    output m1_cmd_t          cmd,
    output logic             commit,
    input  wire              mem_done,
    input  wire [31:0]       mem_rdata,
    input  wire              addr_err,
    input  wire [31:0]       cp0_rdata,
    input  wire              exc_taken,
    input  wire              flush
);

    es_to_m1_t   bus_q;     // pipeline register
    logic        valid_q;
    logic        is_mem;
    logic        is_load;
    logic        ready_go;
    logic [31:0] result;
    m1_to_ms_t   live_bus;
    m1_to_ms_t   held_bus;  // snapshot while the next stage stalls
    logic        held;

    assign is_mem  = (bus_q.mem_op != MEM_NONE);
    assign is_load = (bus_q.mem_op == MEM_LW) || (bus_q.mem_op == MEM_LB)
                     || (bus_q.mem_op == MEM_LBU);

    // excepting items never touch the cache
    assign ready_go  = exc_taken || !is_mem || mem_done;
    assign out_valid = valid_q && ready_go;
    assign commit    = out_valid && ms_allowin;  // advance edge
    assign allowin   = !valid_q || commit;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;  // drop whatever is offered too
        end else if (allowin) begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            bus_q <= in_bus;
        end
    end

    always_comb begin
        cmd.valid    = valid_q;
        cmd.pc       = bus_q.pc;
        cmd.addr     = bus_q.alu_result;
        cmd.wdata    = bus_q.rt_value;
        cmd.mem_op   = bus_q.mem_op;
        cmd.is_mfc0  = bus_q.is_mfc0;
        cmd.is_mtc0  = bus_q.is_mtc0;
        cmd.is_eret  = bus_q.is_eret;
        cmd.cp0_addr = bus_q.cp0_addr;
        cmd.bd       = bus_q.bd;
        cmd.ex       = bus_q.ex;
        cmd.ex_code  = bus_q.ex_code;
    end

    // result select
    always_comb begin
        if (is_load) begin
            result = mem_rdata;
        end else if (bus_q.is_mfc0) begin
            result = cp0_rdata;
        end else begin
            result = bus_q.alu_result;
        end
    end

    always_comb begin
        live_bus.pc     = bus_q.pc;
        live_bus.result = result;
        live_bus.dest   = bus_q.dest;
        live_bus.gr_we  = bus_q.gr_we && !exc_taken;  // no writeback on exception
        live_bus.ex     = exc_taken;
    end

    // cause IP keeps moving, so freeze the bundle once it stalls
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else if (commit) begin
            held <= 1'b0;
        end else if (out_valid && !ms_allowin) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_valid && !held) begin
            held_bus <= live_bus;
        end
    end

    assign out_bus = held ? held_bus : live_bus;

    // forwarding to decode
    always_comb begin
        fwd.dest   = (valid_q && out_bus.gr_we) ? out_bus.dest : 5'd0;
        fwd.result = out_bus.result;
        // misaligned load never reaches the cache
        fwd.load_pending = valid_q && is_load && !mem_done && !addr_err && !exc_taken;
    end

endmodule

`default_nettype wire

// ==== verilog/m1_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module m1_top import m1_pkg::*; (
    input  wire              clk,
    input  wire              reset,
    input  wire [5:0]        ext_int,
    input  wire              in_valid,
    input  wire es_to_m1_t   in_bus,
    output logic             allowin,
    output logic             out_valid,
    output m1_to_ms_t        out_bus,
    input  wire              ms_allowin,
    output m1_fwd_t          fwd,
    output logic             flush,
    output logic [31:0]      flush_target,
    output logic             req,
    output dcache_req_t      req_bus,
    input  wire              addr_ok,
    input  wire              data_ok,
    input  wire [31:0]       rdata
);

    m1_cmd_t     cmd;        // current item, to both parts
    logic        commit;
    logic        mem_done;
    logic [31:0] mem_rdata;  // already extended
    logic        addr_err;
    logic [31:0] bad_addr;
    logic [31:0] cp0_rdata;
    logic        int_pending;
    logic        exc_taken;

    m1_stage u_stage (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .allowin    (allowin),
        .out_valid  (out_valid),
        .out_bus    (out_bus),
        .ms_allowin (ms_allowin),
        .fwd        (fwd),
        .cmd        (cmd),
        .commit     (commit),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .addr_err   (addr_err),
        .cp0_rdata  (cp0_rdata),
        .exc_taken  (exc_taken),
        .flush      (flush)
    );

    dcache_req u_dcache_req (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .int_pending (int_pending),  // no access for an item about to trap
        .commit      (commit),
        .req         (req),
        .req_bus     (req_bus),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .addr_err    (addr_err),
        .bad_addr    (bad_addr)
    );

    cp0_regs u_cp0_regs (
        .clk          (clk),
        .reset        (reset),
        .ext_int      (ext_int),
        .cmd          (cmd),
        .commit       (commit),
        .addr_err     (addr_err),
        .bad_addr     (bad_addr),
        .cp0_rdata    (cp0_rdata),
        .int_pending  (int_pending),
        .exc_taken    (exc_taken),
        .flush        (flush),
        .flush_target (flush_target)
    );

endmodule

`default_nettype wire

// ==== test/m1_ref_model.svh ====
`ifndef M1_REF_MODEL_SVH
`define M1_REF_MODEL_SVH

// bundle the stage should hand on, plus the flush at its commit
typedef struct packed {
    m1_to_ms_t   bus;
    logic        flush;
    logic [31:0] target;
    logic        load;    // waits on the cache before it can leave
} expect_t;

expect_t     exp_q[$];    // accepted bundles, oldest first
dcache_req_t mreq_q[$];   // requests the cache still has to see, wdata masked to strobes
logic [31:0] mem_m [16];  // words 0x1000..0x103c
logic [31:0] status_m;
logic [31:0] epc_m;
logic [31:0] badvaddr_m;
logic        bd_m;
logic [4:0]  code_m;
logic [1:0]  ip_sw_m;     // cause IP[1:0], software bits

// fill pattern of the cache memory
function automatic logic [31:0] init_word(input int i);
    return (32'h0000_1000 + 32'(i) * 4) ^ 32'h5a5a_0000;
endfunction

task automatic reset_model();
    status_m   = `STATUS_RESET;
    epc_m      = '0;
    badvaddr_m = '0;
    bd_m       = 1'b0;
    code_m     = '0;
    ip_sw_m    = '0;
    for (int i = 0; i < 16; i++) begin
        mem_m[i] = init_word(i);
    end
endtask

// mfc0 view, irq is cause IP[7:2] as latched at acceptance
function automatic logic [31:0] read_cp0(input cp0_addr_t num, input logic [5:0] irq);
    case (num)
        BADVADDR: return badvaddr_m;
        STATUS:   return status_m;
        CAUSE:    return {bd_m, 15'd0, irq, ip_sw_m, 1'b0, code_m, 2'b00};
        EPC:      return epc_m;
        default:  return 32'd0;
    endcase
endfunction

// expected outcome of one accepted bundle, cp0 and memory move on in program order
task automatic accept_bundle(input es_to_m1_t b, input logic [5:0] irq);
    expect_t     e;
    dcache_req_t r;
    logic        is_load;
    logic        is_store;
    logic        irq_hit;
    logic        exc;
    logic [1:0]  lane;
    logic [3:0]  idx;
    logic [7:0]  byte_v;
    lane     = b.alu_result[1:0];
    idx      = b.alu_result[5:2];
    is_load  = (b.mem_op == MEM_LW) || (b.mem_op == MEM_LB) || (b.mem_op == MEM_LBU);
    is_store = (b.mem_op == MEM_SW) || (b.mem_op == MEM_SB);
    irq_hit  = status_m[0] && !status_m[1] && (|({irq, ip_sw_m} & status_m[15:8]));
    exc      = irq_hit || b.ex || ((b.mem_op == MEM_LW || b.mem_op == MEM_SW) && lane != 2'b00);
    e.bus.pc     = b.pc;
    e.bus.dest   = b.dest;
    e.bus.gr_we  = b.gr_we && !exc;
    e.bus.ex     = exc;
    e.bus.result = b.is_mfc0 ? read_cp0(b.cp0_addr, irq) : b.alu_result;
    e.flush      = exc || b.is_eret;
    e.target     = exc ? `EXC_VECTOR : epc_m;  // eret goes back to epc
    e.load       = is_load && !exc;
    byte_v       = 8'(mem_m[idx] >> (8 * lane));
    if (exc) begin
        status_m[1] = 1'b1;
        bd_m        = b.bd;
        epc_m       = b.bd ? b.pc - 32'd4 : b.pc;
        if (irq_hit) begin
            code_m = EXC_INT;
        end else if (b.ex) begin
            code_m = b.ex_code;
        end else begin
            code_m     = is_store ? EXC_ADES : EXC_ADEL;
            badvaddr_m = b.alu_result;
        end
    end else if (b.is_eret) begin
        status_m[1] = 1'b0;
    end else if (b.is_mtc0) begin
        case (b.cp0_addr)
            STATUS:  status_m = (status_m & ~`STATUS_WMASK) | (b.rt_value & `STATUS_WMASK);
            CAUSE:   ip_sw_m  = b.rt_value[9:8];
            EPC:     epc_m    = b.rt_value;
            default: ;
        endcase
    end else if (is_load || is_store) begin
        r.op    = is_store;
        r.addr  = b.alu_result;
        r.wstrb = (b.mem_op == MEM_SW) ? 4'hf : (b.mem_op == MEM_SB) ? 4'h1 << lane : 4'h0;
        r.wdata = (b.mem_op == MEM_SW) ? b.rt_value
                : (b.mem_op == MEM_SB) ? {24'd0, b.rt_value[7:0]} << (8 * lane) : 32'd0;
        mreq_q.push_back(r);
        case (b.mem_op)
            MEM_SW:  mem_m[idx] = b.rt_value;
            MEM_SB:  mem_m[idx][8 * lane +: 8] = b.rt_value[7:0];
            MEM_LB:  e.bus.result = {{24{byte_v[7]}}, byte_v};
            MEM_LBU: e.bus.result = {24'd0, byte_v};
            default: e.bus.result = mem_m[idx];  // lw
        endcase
    end
    exp_q.push_back(e);
endtask

`endif

// ==== test/tb_m1_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "m1_defines.svh"

module tb_m1_top import m1_pkg::*; ();

    localparam int N_ITEMS   = 400;
    localparam int RESET_CYC = 16;
    localparam int MAX_CYC   = 40 * N_ITEMS + RESET_CYC;

    logic        clk;
    logic        reset;
    logic [5:0]  ext_int;
    logic        in_valid;
    es_to_m1_t   in_bus;
    logic        allowin;
    logic        out_valid;
    m1_to_ms_t   out_bus;
    logic        ms_allowin;
    m1_fwd_t     fwd;
    logic        flush;
    logic [31:0] flush_target;
    logic        req;
    dcache_req_t req_bus;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;

    integer      seed;
    int          errors;
    int          checks;
    int          n_gen;
    int          n_acc;
    int          n_out;
    int          cycles;
    logic        taken;       // offered bundle went in at the last edge
    logic        stalled;     // out_valid with ms_allowin low at the last edge
    m1_to_ms_t   stall_bus;
    logic        data_back;   // data_ok already seen for the item in the stage
    logic [31:0] resp_mem [16];
    logic [1:0]  aok_wait;    // cycles until addr_ok
    logic [1:0]  dok_wait;    // extra cycles until data_ok
    logic        dok_pend;
    logic [31:0] dok_data;

    `include "m1_ref_model.svh"

    m1_top dut (
        .clk          (clk),
        .reset        (reset),
        .ext_int      (ext_int),
        .in_valid     (in_valid),
        .in_bus       (in_bus),
        .allowin      (allowin),
        .out_valid    (out_valid),
        .out_bus      (out_bus),
        .ms_allowin   (ms_allowin),
        .fwd          (fwd),
        .flush        (flush),
        .flush_target (flush_target),
        .req          (req),
        .req_bus      (req_bus),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = %h, expected %h (t=%0t)", name, got, exp, $time);
        end
    endtask

    task automatic make_bundle(output es_to_m1_t b);
        int         kind;
        logic [1:0] lane;
        kind = {$random(seed)} % 16;
        lane = 2'($random(seed));
        b = '0;
        b.pc         = 32'hbfc0_0000 + 32'(n_gen) * 4;
        b.alu_result = $random(seed);
        b.rt_value   = $random(seed);
        b.dest       = 5'($random(seed));
        b.bd         = ({$random(seed)} % 8) == 0;
        b.gr_we      = 1'b1;
        case (kind)
            4, 5:   b.mem_op = MEM_LW;
            6:      b.mem_op = MEM_LB;
            7:      b.mem_op = MEM_LBU;
            8:      b.mem_op = MEM_SW;
            9:      b.mem_op = MEM_SB;
            10, 11: b.is_mtc0 = 1'b1;
            12, 13: b.is_mfc0 = 1'b1;
            14:     b.is_eret = 1'b1;
            15: begin
                b.ex      = 1'b1;  // raised upstream
                b.ex_code = (kind[0] ^ seed[3]) ? EXC_SYS : EXC_RI;
            end
            default: ;  // plain alu
        endcase
        if (b.mem_op == MEM_LW || b.mem_op == MEM_SW) begin
            lane = (({$random(seed)} % 6) == 0) ? lane : 2'b00;  // mostly aligned words
        end
        if (b.mem_op != MEM_NONE) begin
            b.alu_result = 32'h0000_1000 + {26'd0, 4'($random(seed)), lane};
        end
        if (b.is_mtc0 || b.is_mfc0) begin
            case ({$random(seed)} % 5)
                0:       b.cp0_addr = STATUS;
                1:       b.cp0_addr = CAUSE;
                2:       b.cp0_addr = EPC;
                3:       b.cp0_addr = BADVADDR;
                default: b.cp0_addr = cp0_addr_t'(5'($random(seed))); // mostly unmapped
            endcase
        end
        if (b.is_mtc0 && b.cp0_addr == STATUS && ({$random(seed)} % 4) != 0) begin
            b.rt_value[1] = 1'b0;  // keep EXL clear so interrupts can hit
        end
        if (kind >= 8 && kind <= 11 || kind == 14) begin
            b.gr_we = 1'b0;
        end
    endtask

    // everything seen on one rising edge, values from before the edge
    task automatic observe_edge();
        expect_t     e;
        expect_t     cur;
        dcache_req_t r;
        logic [31:0] mask;
        if (stalled) begin
            check_value("out_valid", out_valid, 1'b1);  // must not drop while stalled
            check_value("out_bus.pc", out_bus.pc, stall_bus.pc);
            check_value("out_bus.result", out_bus.result, stall_bus.result);
            check_value("out_bus.dest/gr_we/ex", {out_bus.dest, out_bus.gr_we, out_bus.ex},
                        {stall_bus.dest, stall_bus.gr_we, stall_bus.ex});
        end
        stalled   = out_valid && !ms_allowin;
        stall_bus = out_bus;
        // item sitting in the stage, if any
        if (exp_q.size() != 0) begin
            cur = exp_q[0];
        end else begin
            cur = '0;
        end
        check_value("fwd.dest", fwd.dest, cur.bus.gr_we ? cur.bus.dest : 5'd0);
        check_value("fwd.load_pending", fwd.load_pending, cur.load && !data_back);
        if (out_valid && ms_allowin) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a bundle left the stage with none expected, pc %h", out_bus.pc);
            end else begin
                e = exp_q.pop_front();
                n_out++;
                data_back = 1'b0;
                check_value("out_bus.pc", out_bus.pc, e.bus.pc);
                check_value("out_bus.dest", out_bus.dest, e.bus.dest);
                check_value("out_bus.gr_we", out_bus.gr_we, e.bus.gr_we);
                check_value("out_bus.ex", out_bus.ex, e.bus.ex);
                if (!e.bus.ex) begin
                    check_value("out_bus.result", out_bus.result, e.bus.result);
                    check_value("fwd.result", fwd.result, e.bus.result);
                end
                check_value("flush", flush, e.flush);
                if (e.flush) begin
                    check_value("flush_target", flush_target, e.target);
                end
            end
        end else begin
            check_value("flush", flush, 1'b0);  // only on commit
        end
        if (req && addr_ok) begin
            if (mreq_q.size() == 0) begin
                errors++;
                $display("cache request with no memory access expected, addr %h", req_bus.addr);
            end else begin
                r    = mreq_q.pop_front();
                mask = {{8{r.wstrb[3]}}, {8{r.wstrb[2]}}, {8{r.wstrb[1]}}, {8{r.wstrb[0]}}};
                check_value("req_bus.op", req_bus.op, r.op);
                check_value("req_bus.addr", req_bus.addr, r.addr);
                check_value("req_bus.wstrb", req_bus.wstrb, r.wstrb);
                check_value("req_bus.wdata", req_bus.wdata & mask, r.wdata);
            end
            for (int k = 0; k < 4; k++) begin
                if (req_bus.op && req_bus.wstrb[k]) begin
                    resp_mem[req_bus.addr[5:2]][8 * k +: 8] = req_bus.wdata[8 * k +: 8];
                end
            end
            dok_data = resp_mem[req_bus.addr[5:2]];
            dok_pend = 1'b1;
            dok_wait = 2'($random(seed));
            aok_wait = 2'($random(seed));
        end
        if (data_ok) begin
            dok_pend  = 1'b0;
            data_back = 1'b1;
        end
        if (in_valid && allowin && !flush) begin  // flush drops the offered bundle
            accept_bundle(in_bus, ext_int);
            taken = 1'b1;
            n_acc++;
        end
    endtask

    task automatic drive_inputs();
        es_to_m1_t b;
        if (taken || !in_valid) begin
            taken = 1'b0;
            if (n_gen < N_ITEMS && ({$random(seed)} % 4) != 0) begin
                make_bundle(b);
                in_bus   = b;
                in_valid = 1'b1;
                n_gen++;
            end else begin
                in_valid = 1'b0;
            end
        end
        ms_allowin = ({$random(seed)} % 4) != 0;
        ext_int    = (({$random(seed)} % 8) == 0) ? 6'($random(seed)) : 6'd0;
        // cache responder
        addr_ok = 1'b0;
        if (req) begin
            if (aok_wait == 0) begin
                addr_ok = 1'b1;
            end else begin
                aok_wait--;
            end
        end
        data_ok = 1'b0;
        if (dok_pend) begin
            if (dok_wait == 0) begin
                data_ok = 1'b1;
                rdata   = dok_data;
            end else begin
                dok_wait--;
            end
        end
    endtask

    initial begin
        seed       = 32'hc144;
        errors     = 0;
        checks     = 0;
        n_gen      = 0;
        n_acc      = 0;
        n_out      = 0;
        reset      = 1'b1;
        ext_int    = '0;
        in_valid   = 1'b0;
        in_bus     = '0;
        ms_allowin = 1'b0;
        addr_ok    = 1'b0;
        data_ok    = 1'b0;
        rdata      = '0;
        taken      = 1'b0;
        stalled    = 1'b0;
        stall_bus  = '0;
        data_back  = 1'b0;
        aok_wait   = '0;
        dok_wait   = '0;
        dok_pend   = 1'b0;
        dok_data   = '0;
        reset_model();
        for (int i = 0; i < 16; i++) begin
            resp_mem[i] = init_word(i);
        end
        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("out_valid", out_valid, 1'b0);  // state right after reset
        check_value("req", req, 1'b0);
        check_value("flush", flush, 1'b0);
        check_value("fwd.dest", fwd.dest, 5'd0);
        while (n_out < N_ITEMS) begin
            @(negedge clk);
            drive_inputs();
            #1;
            observe_edge();  // settled values the coming rising edge takes
        end
        if (exp_q.size() != 0 || mreq_q.size() != 0) begin
            errors++;
            $display("bundles or cache requests still expected at the end of the run");
        end
        $display("checks: %0d, errors: %0d, bundles: %0d", checks, errors, n_acc);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < MAX_CYC) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d of %0d bundles left the stage",
                 cycles, n_out, N_ITEMS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== m1_top.f ====
+incdir+verilog
+incdir+test
verilog/m1_pkg.sv
verilog/dcache_req.sv
verilog/cp0_regs.sv
verilog/m1_stage.sv
verilog/m1_top.sv
test/tb_m1_top.sv

// ==== Bender.yml ====
package:
  name: m1_top

dependencies: {}

sources:
  # memory stage rtl, package first
  - include_dirs:
      - verilog
    files:
      - verilog/m1_pkg.sv
      - verilog/dcache_req.sv
      - verilog/cp0_regs.sv
      - verilog/m1_stage.sv
      - verilog/m1_top.sv

  # testbench with its reference model header
  - target: test
    include_dirs:
      - verilog
      - test
    files:
      - test/tb_m1_top.sv
